//--- project.f
source/conv_pkg.sv
source/conv_ctrl.sv
source/window_fetch.sv
source/mac_requant.sv
source/conv_top.sv
sim/conv_checker.sv
sim/tb_conv.sv

//--- sim/conv_checker.sv
`timescale 1ns/1ns

module conv_checker import conv_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      start,
  input codebook_t codebook,
  input logic      out_wr_valid,
  input out_wr_t   out_wr,
  input logic      done
);

  codebook_t         cb_q;
  logic [addr_w-1:0] addr_q [$];
  pixel_t            data_q [$];
  int cycle         = 0;
  int last_wr_cycle = 0;
  int done_cycle    = 0;
  int done_count    = 0;
  int late_writes   = 0;
  int tests_run     = 0;
  int tests_failed  = 0;
  int error_count   = 0;

  always @(posedge clk) begin
    cycle++;
    if (rst) begin
      if (start) begin
        cb_q = codebook;
        addr_q.delete();
        data_q.delete();
        done_count  = 0;
        late_writes = 0;
      end
      if (out_wr_valid && done_count > 0) begin
        late_writes++;
      end else if (out_wr_valid) begin
        addr_q.push_back(out_wr.addr);
        data_q.push_back(out_wr.data);
        last_wr_cycle = cycle;
      end
      if (done) begin
        done_count++;
        done_cycle = cycle;
      end
    end
  end

  function automatic int requant(input int a);
    int t;
    t = a >>> quant_shift;
    if (a >= 0) return (t > quant_max) ? quant_max : t;
    if (t < quant_min) return quant_min;
    return t + 1;
  endfunction

  function automatic int expected_out(input int k, input int n, input int y, input int x);
    int      acc;
    int      py;
    int      px;
    wsel_t   w;
    weight_t wt;
    pixel_t  p;
    acc = tb_conv.bias_mem[k];
    w   = tb_conv.weight_mem[k];
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        py = y + r - 1;
        px = x + c - 1;
        // padding taps add nothing
        if (py >= 0 && py < n && px >= 0 && px < n) begin
          p   = tb_conv.pixel_mem[py*n + px];
          wt  = cb_q[w[3*r + c]];
          acc += int'(p) * int'(wt);
        end
      end
    end
    return requant(acc);
  endfunction

  task automatic finish_test(input string name, input int exp_first);
    int n;
    int total;
    int errs;
    int p;
    int exp_data;
    n     = tb_conv.param_mem[0];
    total = int'(tb_conv.param_mem[1]) * n * n;
    errs  = 0;
    if (done_count != 1) begin
      $display("%s: done seen %0d times instead of once", name, done_count);
      errs++;
    end
    if (data_q.size() != total) begin
      $display("%s: %0d output writes, %0d expected", name, data_q.size(), total);
      errs++;
    end
    if (late_writes > 0) begin
      $display("%s: %0d output writes arrived after done", name, late_writes);
      errs++;
    end
    if (done_count > 0 && data_q.size() > 0 && done_cycle <= last_wr_cycle) begin
      $display("%s: done came before the last output write", name);
      errs++;
    end
    for (int i = 0; i < data_q.size() && i < total; i++) begin
      p        = i % (n*n);
      exp_data = expected_out(i / (n*n), n, p / n, p % n);
      if (int'(addr_q[i]) != i) begin
        $display("ERR %s write %0d addr expected %0d actual %0d", name, i, i, addr_q[i]);
        errs++;
      end
      if (int'(data_q[i]) != exp_data) begin
        $display("ERR %s write %0d data expected %0d actual %0d",
                 name, i, exp_data, data_q[i]);
        errs++;
      end
    end
    // hand-derived value from the table
    if (exp_first >= quant_min && exp_first <= quant_max && data_q.size() > 0) begin
      if (int'(data_q[0]) != exp_first) begin
        $display("ERR %s first output expected %0d actual %0d", name, exp_first, data_q[0]);
        errs++;
      end
    end
    if (errs == 0) $display("PASS %s: %0d writes", name, data_q.size());
    else $display("FAIL %s: %0d errors", name, errs);
    tests_run++;
    if (errs != 0) tests_failed++;
    error_count += errs;
  endtask

endmodule

//--- sim/tb_conv.sv
`timescale 1ns/1ns

module tb_conv import conv_pkg::*; ();

  localparam int n_tests = 8;
  // table marker for rows with no hand-derived first output
  localparam int no_exp  = 999;

  logic               clk;
  logic               rst;
  logic               start;
  codebook_t          codebook;
  logic [param_w-1:0] param_rdata;
  bias_t              bias_rdata;
  wsel_t              weight_rdata;
  pixel_t             pixel_rdata;
  mem_req_t           param_req;
  mem_req_t           bias_req;
  mem_req_t           weight_req;
  mem_req_t           pixel_req;
  logic               out_wr_valid;
  out_wr_t            out_wr;
  logic               done;

  logic [param_w-1:0] param_mem  [4];
  bias_t              bias_mem   [max_kernel];
  wsel_t              weight_mem [max_kernel];
  pixel_t             pixel_mem  [max_row*max_row];

  // test table
  string       t_name [n_tests];
  int          t_row  [n_tests];
  int          t_kern [n_tests];
  logic [31:0] t_cb   [n_tests];
  bit          t_rand [n_tests];
  pixel_t      t_pix  [n_tests];
  wsel_t       t_wsel [n_tests];
  bias_t       t_bias [n_tests];
  int          t_exp  [n_tests];

  int unsigned lcg_state;
  int          limit_cycles;

  conv_top dut (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .codebook     (codebook),
    .param_rdata  (param_rdata),
    .bias_rdata   (bias_rdata),
    .weight_rdata (weight_rdata),
    .pixel_rdata  (pixel_rdata),
    .param_req    (param_req),
    .bias_req     (bias_req),
    .weight_req   (weight_req),
    .pixel_req    (pixel_req),
    .out_wr_valid (out_wr_valid),
    .out_wr       (out_wr),
    .done         (done)
  );

  conv_checker chk (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .codebook     (codebook),
    .out_wr_valid (out_wr_valid),
    .out_wr       (out_wr),
    .done         (done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // memories answer one cycle after the request
  always @(posedge clk) begin
    if (param_req.rd) param_rdata <= #2 param_mem[param_req.addr];
    if (bias_req.rd) bias_rdata <= #2 bias_mem[bias_req.addr];
    if (weight_req.rd) weight_rdata <= #2 weight_mem[weight_req.addr];
    if (pixel_req.rd) pixel_rdata <= #2 pixel_mem[pixel_req.addr];
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;
  endfunction

  task automatic set_row(input int i, input string name, input int n, input int nk,
                         input logic [31:0] cb, input bit rnd, input pixel_t pix,
                         input wsel_t w, input bias_t b, input int exp_first);
    t_name[i] = name;
    t_row[i]  = n;
    t_kern[i] = nk;
    t_cb[i]   = cb;
    t_rand[i] = rnd;
    t_pix[i]  = pix;
    t_wsel[i] = w;
    t_bias[i] = b;
    t_exp[i]  = exp_first;
  endtask

  task automatic fill_mems(input int i);
    param_mem[0] = param_w'(t_row[i]);
    param_mem[1] = param_w'(t_kern[i]);
    for (int k = 0; k < max_kernel; k++) begin
      bias_mem[k]   = t_rand[i] ? bias_t'(int'(lcg_next() % 1024) - 512) : t_bias[i];
      weight_mem[k] = t_rand[i] ? wsel_t'(lcg_next()) : t_wsel[i];
    end
    for (int p = 0; p < max_row*max_row; p++) begin
      if (t_rand[i]) pixel_mem[p] = pixel_t'(lcg_next());
      else if (p < t_row[i]*t_row[i]) pixel_mem[p] = t_pix[i];
      else pixel_mem[p] = pixel_t'(p ^ 8'hA5);
    end
  endtask

  task automatic pulse_start(input logic [31:0] cb);
    @(posedge clk);
    #2;
    start    = 1'b1;
    codebook = cb;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired: done never arrived for a test");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int lim;
    rst          = 1'b0;
    start        = 1'b0;
    codebook     = '0;
    param_rdata  = '0;
    bias_rdata   = '0;
    weight_rdata = '0;
    pixel_rdata  = '0;
    lcg_state    = 77570;
    limit_cycles = 0;

    set_row(0, "one_px",    1, 1, 32'h11223340, 0, 8'sd5,  18'h00000, 16'sd0,  10);
    set_row(1, "two_px",    2, 1, 32'h05060720, 0, 8'sd3,  18'h00000, 16'sd0,  12);
    set_row(2, "ones_3x3",  3, 1, 32'h01200304, 0, 8'sd1,  18'h2AAAA, 16'sd0,  4);
    set_row(3, "sat_pos",   4, 1, 32'h80007F00, 0, 8'sd127, 18'h15555, 16'sd0, 127);
    set_row(4, "sat_neg",   4, 1, 32'h80101010, 0, 8'sd127, 18'h3FFFF, 16'sd0, -128);
    set_row(5, "neg_round", 3, 1, 32'hF0F0F005, 0, -8'sd3, 18'h00000, 16'sd10, -1);
    set_row(6, "rand_8x8",  8, 3, 32'hD35A17F9, 1, 8'sd0,  18'h00000, 16'sd0,  no_exp);
    set_row(7, "restart",   5, 2, 32'h4D039C0C, 1, 8'sd0,  18'h00000, 16'sd0,  no_exp);

    repeat (16) @(posedge clk);
    #2;
    rst = 1'b1;

    lim = 0;
    for (int i = 0; i < n_tests; i++) begin
      lim += t_kern[i] * t_row[i] * t_row[i] * 12 + 100;
    end
    limit_cycles = lim;

    for (int i = 0; i < n_tests; i++) begin
      fill_mems(i);
      pulse_start(t_cb[i]);
      @(posedge clk);
      while (!done) @(posedge clk);
      // a few idle cycles catch any write after done
      repeat (4) @(posedge clk);
      chk.finish_test(t_name[i], t_exp[i]);
    end

    $display("tests %0d, failed %0d, errors %0d",
             chk.tests_run, chk.tests_failed, chk.error_count);
    if (chk.error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- source/conv_ctrl.sv
`timescale 1ns/1ns

module conv_ctrl import conv_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  codebook_t          codebook,
  input  logic [param_w-1:0] param_rdata,
  input  bias_t              bias_rdata,
  input  wsel_t              weight_rdata,
  output mem_req_t           param_req,
  output mem_req_t           bias_req,
  output mem_req_t           weight_req,
  output logic               sweep_start,
  output logic [dim_w-1:0]   num_row,
  output kernel_t            kernel,
  output bias_t              bias,
  input  logic               sweep_done,
  output logic               done
);

  enum logic [2:0] {st_idle, st_param, st_kload, st_sweep, st_drain, st_done} state;

  logic [1:0]        phase;
  logic [kcnt_w-1:0] num_kernel;
  logic [kcnt_w-1:0] kernel_idx;
  codebook_t         cb;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state      <= st_idle;
      phase      <= '0;
      kernel_idx <= '0;
    end else begin
      case (state)
        st_idle: begin
          phase <= '0;
          if (start) state <= st_param;
        end
        st_param: begin
          if (phase == 2'd2) begin
            state      <= st_kload;
            phase      <= '0;
            kernel_idx <= '0;
          end else begin
            phase <= phase + 1'b1;
          end
        end
        st_kload: begin
          if (phase == 2'd2) begin
            state <= st_sweep;
            phase <= '0;
          end else begin
            phase <= phase + 1'b1;
          end
        end
        st_sweep: begin
          if (sweep_done) state <= st_drain;
        end
        // two cycles for the last window to leave the pipeline
        st_drain: begin
          if (phase == 2'd1) begin
            phase <= '0;
            if (kernel_idx == num_kernel - 1'b1) begin
              state <= st_done;
            end else begin
              kernel_idx <= kernel_idx + 1'b1;
              state      <= st_kload;
            end
          end else begin
            phase <= phase + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // image parameters, words 0 and 1
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      num_row    <= '0;
      num_kernel <= '0;
    end else if (state == st_param) begin
      if (phase == 2'd1) num_row <= param_rdata[dim_w-1:0];
      if (phase == 2'd2) num_kernel <= param_rdata[kcnt_w-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && start) cb <= codebook;
    if (state == st_kload && phase == 2'd1) begin
      bias <= bias_rdata;
      // codebook lookup per tap
      for (int k = 0; k < taps; k++) begin
        kernel[k] <= cb[weight_rdata[k]];
      end
    end
  end

  always_comb begin
    param_req.rd   = (state == st_param) && (phase != 2'd2);
    param_req.addr = addr_w'(phase);
    bias_req.rd    = (state == st_kload) && (phase == 2'd0);
    bias_req.addr  = addr_w'(kernel_idx);
    weight_req     = bias_req;
  end

  assign sweep_start = (state == st_kload) && (phase == 2'd2);
  assign done        = (state == st_done);

  a_row_range: assert property (@(posedge clk) disable iff (!rst)
    (state == st_param && phase == 2'd1) |=> (num_row >= 1 && num_row <= max_row));

endmodule

//--- source/conv_pkg.sv
package conv_pkg;

  // image and kernel limits
  localparam int max_row    = 16;
  localparam int max_kernel = 16;
  localparam int kcnt_w     = $clog2(max_kernel + 1);

  localparam int addr_w  = 12;
  localparam int dim_w   = 5;
  localparam int param_w = 16;
  localparam int taps    = 9;

  // requantize
  localparam int quant_shift = 5;
  localparam int quant_max   = 127;
  localparam int quant_min   = -128;

  typedef logic signed [7:0] pixel_t;
  typedef logic signed [7:0] weight_t;

  // entry 0 in the low byte
  typedef weight_t [3:0] codebook_t;

  // tap 0 top-left, tap 4 center, tap 8 bottom-right
  typedef pixel_t  [taps-1:0] window_t;
  typedef weight_t [taps-1:0] kernel_t;

  // 2-bit codebook index per tap
  typedef logic [taps-1:0][1:0] wsel_t;

  typedef logic signed [15:0] bias_t;
  typedef logic signed [19:0] acc_t;

  typedef struct packed {
    logic              rd;
    logic [addr_w-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    pixel_t            data;
  } out_wr_t;

endpackage

//--- source/conv_top.sv
`timescale 1ns/1ns

module conv_top import conv_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  codebook_t          codebook,
  input  logic [param_w-1:0] param_rdata,
  input  bias_t              bias_rdata,
  input  wsel_t              weight_rdata,
  input  pixel_t             pixel_rdata,
  output mem_req_t           param_req,
  output mem_req_t           bias_req,
  output mem_req_t           weight_req,
  output mem_req_t           pixel_req,
  output logic               out_wr_valid,
  output out_wr_t            out_wr,
  output logic               done
);

  logic             sweep_start;
  logic             sweep_done;
  logic [dim_w-1:0] num_row;
  kernel_t          kernel;
  bias_t            bias;
  logic             win_valid;
  window_t          window;

  conv_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .codebook     (codebook),
    .param_rdata  (param_rdata),
    .bias_rdata   (bias_rdata),
    .weight_rdata (weight_rdata),
    .param_req    (param_req),
    .bias_req     (bias_req),
    .weight_req   (weight_req),
    .sweep_start  (sweep_start),
    .num_row      (num_row),
    .kernel       (kernel),
    .bias         (bias),
    .sweep_done   (sweep_done),
    .done         (done)
  );

  window_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .sweep_start (sweep_start),
    .num_row     (num_row),
    .pixel_req   (pixel_req),
    .pixel_rdata (pixel_rdata),
    .win_valid   (win_valid),
    .window      (window),
    .sweep_done  (sweep_done)
  );

  mac_requant u_mac (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .win_valid    (win_valid),
    .window       (window),
    .kernel       (kernel),
    .bias         (bias),
    .out_wr_valid (out_wr_valid),
    .out_wr       (out_wr)
  );

endmodule

//--- source/mac_requant.sv
`timescale 1ns/1ns

module mac_requant import conv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  logic    win_valid,
  input  window_t window,
  input  kernel_t kernel,
  input  bias_t   bias,
  output logic    out_wr_valid,
  output out_wr_t out_wr
);

  logic signed [15:0] prod [taps];
  logic               s1_valid;
  logic [addr_w-1:0]  wr_addr;
  acc_t               acc;
  acc_t               acc_sh;
  pixel_t             q;

  // stage 1
  always_ff @(posedge clk) begin
    if (win_valid) begin
      for (int k = 0; k < taps; k++) begin
        prod[k] <= window[k] * kernel[k];
      end
    end
  end

  always_comb begin
    acc = acc_t'(bias);
    for (int k = 0; k < taps; k++) begin
      acc = acc + acc_t'(prod[k]);
    end
  end

  assign acc_sh = acc >>> quant_shift;

  // negative results round up by one
  always_comb begin
    if (!acc[$bits(acc_t)-1]) begin
      q = (acc_sh > quant_max) ? pixel_t'(quant_max) : acc_sh[7:0];
    end else if (acc_sh < quant_min) begin
      q = pixel_t'(quant_min);
    end else begin
      q = acc_sh[7:0] + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      s1_valid     <= 1'b0;
      out_wr_valid <= 1'b0;
      wr_addr      <= '0;
    end else begin
      s1_valid     <= win_valid;
      out_wr_valid <= s1_valid;
      if (start) wr_addr <= '0;
      else if (s1_valid) wr_addr <= wr_addr + 1'b1;
    end
  end

  // stage 2
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_wr.addr <= wr_addr;
      out_wr.data <= q;
    end
  end

  // bias is added one cycle after the window is taken
  a_bias_stable: assert property (@(posedge clk) disable iff (!rst)
    win_valid |=> $stable(bias));

endmodule

//--- source/window_fetch.sv
`timescale 1ns/1ns

module window_fetch import conv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             sweep_start,
  input  logic [dim_w-1:0] num_row,
  output mem_req_t         pixel_req,
  input  pixel_t           pixel_rdata,
  output logic             win_valid,
  output window_t          window,
  output logic             sweep_done
);

  enum logic [1:0] {st_idle, st_fetch, st_cap, st_emit} state;

  logic [dim_w-1:0]  x;
  logic [dim_w-1:0]  y;
  logic [dim_w-1:0]  nx;
  logic [dim_w-1:0]  ny;
  logic [dim_w-1:0]  last_pos;
  logic [1:0]        r;
  logic [1:0]        r_first;
  logic [1:0]        r_last;
  logic [1:0]        nr_first;
  logic              colsel;
  logic              need_read;
  logic              advance;
  logic              cap_valid;
  logic [3:0]        cap_tap;
  logic [addr_w-1:0] rd_row;

  assign last_pos = num_row - 1'b1;

  // window rows that fall inside the image
  assign r_first = (y == '0) ? 2'd1 : 2'd0;
  assign r_last  = (y == last_pos) ? 2'd1 : 2'd2;

  assign win_valid  = (state == st_emit);
  assign sweep_done = (state == st_emit) && (x == last_pos) && (y == last_pos);
  assign advance    = (state == st_idle && sweep_start) || (state == st_emit && !sweep_done);

  // next pixel in raster order
  always_comb begin
    if (state == st_idle) begin
      nx = '0;
      ny = '0;
    end else if (x == last_pos) begin
      nx = '0;
      ny = y + 1'b1;
    end else begin
      nx = x + 1'b1;
      ny = y;
    end
  end

  assign nr_first = (ny == '0) ? 2'd1 : 2'd0;
  // right column past the edge means no reads at all
  assign need_read = (nx == '0) || (nx < last_pos);

  assign rd_row = addr_w'(y) + addr_w'(r) - 1'b1;

  always_comb begin
    pixel_req.rd   = (state == st_fetch);
    pixel_req.addr = rd_row * addr_w'(num_row) + addr_w'(x) + addr_w'(colsel);
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= st_idle;
      x         <= '0;
      y         <= '0;
      r         <= '0;
      colsel    <= 1'b0;
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= (state == st_fetch);
      if (advance) begin
        x      <= nx;
        y      <= ny;
        colsel <= (nx != '0);
        r      <= nr_first;
        state  <= need_read ? st_fetch : st_emit;
      end else begin
        case (state)
          st_fetch: begin
            if (r == r_last) begin
              // first pixel of a row also loads column 1
              if (!colsel && last_pos != '0) begin
                colsel <= 1'b1;
                r      <= r_first;
              end else begin
                state <= st_cap;
              end
            end else begin
              r <= r + 1'b1;
            end
          end
          st_cap:  state <= st_emit;
          st_emit: state <= st_idle;
          default: state <= state;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    cap_tap <= 4'(r) * 4'd3 + 4'd1 + 4'(colsel);
  end

  always_ff @(posedge clk) begin
    if (cap_valid) begin
      window[cap_tap] <= pixel_rdata;
    end else if (advance) begin
      // clear at row start, else shift left and open an empty right column
      for (int row = 0; row < 3; row++) begin
        window[3*row]   <= (nx == '0) ? pixel_t'(0) : window[3*row+1];
        window[3*row+1] <= (nx == '0) ? pixel_t'(0) : window[3*row+2];
        window[3*row+2] <= pixel_t'(0);
      end
    end
  end

  a_addr_range: assert property (@(posedge clk) disable iff (!rst)
    pixel_req.rd |-> pixel_req.addr < addr_w'(num_row) * addr_w'(num_row));

endmodule
